//--- bench/recorder_asserts.sv
`timescale 1ns/10ps
`default_nettype none

// protocol checks on the recorder top level
module recorder_asserts #(
   parameter int B_BUF_DEPTH = rr_pkg::B_BUF_DEPTH_DEF
) (
   input wire                        clk,
   input wire                        sync_rst_n,
   input wire                        i_sink_almful,
   input wire                        i_buf_almful,
   input wire                        i_aw_valid,
   input wire                        i_aw_ready,
   input wire                        i_w_valid,
   input wire                        i_w_ready,
   input wire                        i_bin_valid,
   input wire                        i_bin_ready,
   input wire                        i_bout_valid,
   input wire                        i_bout_ready,
   input wire                        i_logb_aw_valid,
   input wire                        i_logb_w_valid,
   input wire                        i_logb_b_valid,
   input wire [rr_pkg::LOGE_CNT-1:0] i_loge_valid
);

   int occ;

   // buffer occupancy seen from its two handshakes
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         occ <= 0;
      end else begin
         case ({i_bin_valid && i_bin_ready, i_bout_valid && i_bout_ready})
            2'b10:   occ <= occ + 1;
            2'b01:   occ <= occ - 1;
            default: occ <= occ;
         endcase
      end
   end

   a_loge_aw: assert property (@(posedge clk) disable iff (!sync_rst_n)
      i_loge_valid[rr_pkg::LOGE_AW] == i_logb_aw_valid)
      else $error("AW logging-end bit differs from the AW record strobe");

   a_loge_w: assert property (@(posedge clk) disable iff (!sync_rst_n)
      i_loge_valid[rr_pkg::LOGE_W] == i_logb_w_valid)
      else $error("W logging-end bit differs from the W record strobe");

   a_loge_b: assert property (@(posedge clk) disable iff (!sync_rst_n)
      i_loge_valid[rr_pkg::LOGE_B] == i_logb_b_valid)
      else $error("B logging-end bit differs from the B record strobe");

   a_aw_blocked: assert property (@(posedge clk) disable iff (!sync_rst_n)
      (i_sink_almful || i_buf_almful) |-> !(i_aw_valid && i_aw_ready))
      else $error("AW transfer while the write path is blocked");

   a_w_blocked: assert property (@(posedge clk) disable iff (!sync_rst_n)
      (i_sink_almful || i_buf_almful) |-> !(i_w_valid && i_w_ready))
      else $error("W transfer while the write path is blocked");

   a_full_bready: assert property (@(posedge clk) disable iff (!sync_rst_n)
      (occ == B_BUF_DEPTH) |-> !i_bin_ready)
      else $error("slave bready high while the response buffer is full");

endmodule

bind axi_write_recorder recorder_asserts #(
   .B_BUF_DEPTH (B_BUF_DEPTH)
) u_recorder_asserts (
   .clk             (clk),
   .sync_rst_n      (sync_rst_n),
   .i_sink_almful   (i_logb_almful),
   .i_buf_almful    (o_b_fifo_almful),
   .i_aw_valid      (o_s_awvalid),
   .i_aw_ready      (i_s_awready),
   .i_w_valid       (o_s_wvalid),
   .i_w_ready       (i_s_wready),
   .i_bin_valid     (i_s_bvalid),
   .i_bin_ready     (o_s_bready),
   .i_bout_valid    (b_buf_valid),
   .i_bout_ready    (b_buf_ready),
   .i_logb_aw_valid (o_logb_aw_valid),
   .i_logb_w_valid  (o_logb_w_valid),
   .i_logb_b_valid  (o_logb_b_valid),
   .i_loge_valid    (o_loge_valid)
);

`default_nettype wire

//--- bench/tb_axi_write_recorder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_write_recorder;

   localparam int B_BUF_DEPTH = 16;
   localparam int B_BUF_SLACK = 4;
   localparam int CLK_PERIOD  = 20;

   // planned length of each phase in cycles
   localparam int RST_CYCLES    = 4;
   localparam int RANDOM_CYCLES = 800;
   localparam int SINK_CYCLES   = 60;
   localparam int RESUME_CYCLES = 100;
   localparam int HOLD_CYCLES   = 200;
   localparam int DRAIN_CYCLES  = 300;
   localparam int TOTAL_CYCLES  = RST_CYCLES + RANDOM_CYCLES + SINK_CYCLES +
                                  RESUME_CYCLES + HOLD_CYCLES + DRAIN_CYCLES;
   localparam int TIMEOUT_CYCLES = 4 * TOTAL_CYCLES;

   logic                        clk;
   logic                        sync_rst_n;
   logic                        i_m_awvalid;
   rr_pkg::axi_aw_t             i_m_aw;
   logic                        o_m_awready;
   logic                        i_m_wvalid;
   rr_pkg::axi_w_t              i_m_w;
   logic                        o_m_wready;
   logic                        o_m_bvalid;
   rr_pkg::axi_b_t              o_m_b;
   logic                        i_m_bready;
   logic                        o_s_awvalid;
   rr_pkg::axi_aw_t             o_s_aw;
   logic                        i_s_awready;
   logic                        o_s_wvalid;
   rr_pkg::axi_w_t              o_s_w;
   logic                        i_s_wready;
   logic                        i_s_bvalid;
   rr_pkg::axi_b_t              i_s_b;
   logic                        o_s_bready;
   logic                        i_logb_almful;
   logic                        o_logb_aw_valid;
   rr_pkg::axi_aw_t             o_logb_aw;
   logic                        o_logb_w_valid;
   rr_pkg::axi_w_t              o_logb_w;
   logic                        o_logb_b_valid;
   rr_pkg::axi_b_t              o_logb_b;
   logic [rr_pkg::LOGE_CNT-1:0] o_loge_valid;
   logic                        o_b_fifo_almful;

   logic [31:0] lfsr_state = 32'd93528;
   string       test_name = "idle";
   bit          check_en;
   bit          gen_en;
   bit          hold_b;
   bit          sink_full;
   // handshakes predicted at a falling edge complete on the next rising edge
   bit          aw_fire;
   bit          w_fire;
   bit          sb_fire;
   bit          mb_fire;
   bit          exp_almful;
   bit          almful_seen;
   bit          drained;
   int          aw_sent;
   int          aw_acc;
   int          b_recv;
   int          cycle_cnt;
   int          w_beats_left;
   int          slv_wlast_cnt;
   int          acc_before;
   logic [rr_pkg::AXI_ID_W-1:0] w_id;
   logic [rr_pkg::AXI_ID_W-1:0] slv_aw_ids[$];
   rr_pkg::axi_aw_t             w_todo[$];
   rr_pkg::axi_aw_t             exp_aw_q[$];
   rr_pkg::axi_w_t              exp_w_q[$];
   rr_pkg::axi_b_t              exp_b_q[$];
   // reference copy of the response buffer contents
   rr_pkg::axi_b_t              ref_buf[$];

   axi_write_recorder #(
      .B_BUF_DEPTH (B_BUF_DEPTH),
      .B_BUF_SLACK (B_BUF_SLACK)
   ) i_dut (
      .clk             (clk),
      .sync_rst_n      (sync_rst_n),
      .i_m_awvalid     (i_m_awvalid),
      .i_m_aw          (i_m_aw),
      .o_m_awready     (o_m_awready),
      .i_m_wvalid      (i_m_wvalid),
      .i_m_w           (i_m_w),
      .o_m_wready      (o_m_wready),
      .o_m_bvalid      (o_m_bvalid),
      .o_m_b           (o_m_b),
      .i_m_bready      (i_m_bready),
      .o_s_awvalid     (o_s_awvalid),
      .o_s_aw          (o_s_aw),
      .i_s_awready     (i_s_awready),
      .o_s_wvalid      (o_s_wvalid),
      .o_s_w           (o_s_w),
      .i_s_wready      (i_s_wready),
      .i_s_bvalid      (i_s_bvalid),
      .i_s_b           (i_s_b),
      .o_s_bready      (o_s_bready),
      .i_logb_almful   (i_logb_almful),
      .o_logb_aw_valid (o_logb_aw_valid),
      .o_logb_aw       (o_logb_aw),
      .o_logb_w_valid  (o_logb_w_valid),
      .o_logb_w        (o_logb_w),
      .o_logb_b_valid  (o_logb_b_valid),
      .o_logb_b        (o_logb_b),
      .o_loge_valid    (o_loge_valid),
      .o_b_fifo_almful (o_b_fifo_almful)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[62:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // flag is high the cycle after occupancy reaches depth minus slack
   function automatic bit almful_ref(input int occ);
      return occ >= B_BUF_DEPTH - B_BUF_SLACK;
   endfunction

   function automatic bit traffic_idle();
      return !i_m_awvalid && !i_m_wvalid && !i_s_bvalid && !aw_fire && !w_fire &&
             !sb_fire && !mb_fire && w_todo.size() == 0 && w_beats_left == 0 &&
             slv_aw_ids.size() == 0 && ref_buf.size() == 0 && exp_aw_q.size() == 0 &&
             exp_w_q.size() == 0 && exp_b_q.size() == 0;
   endfunction

   task automatic report_failure();
      $display("Result: FAILED");
      $fatal(1, "run stopped after a failed check");
   endtask

   task automatic check_aw(input string name, input rr_pkg::axi_aw_t exp,
                           input rr_pkg::axi_aw_t act);
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_w(input string name, input rr_pkg::axi_w_t exp,
                          input rr_pkg::axi_w_t act);
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_b(input string name, input rr_pkg::axi_b_t exp,
                          input rr_pkg::axi_b_t act);
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_bit(input string name, input bit exp, input bit act);
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %b, actual %b", test_name, name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_reset_state();
      check_bit("s_awvalid", 1'b0, o_s_awvalid);
      check_bit("s_wvalid", 1'b0, o_s_wvalid);
      check_bit("m_bvalid", 1'b0, o_m_bvalid);
      check_bit("logb_aw_valid", 1'b0, o_logb_aw_valid);
      check_bit("logb_w_valid", 1'b0, o_logb_w_valid);
      check_bit("logb_b_valid", 1'b0, o_logb_b_valid);
      check_bit("loge_valid", 1'b0, |o_loge_valid);
      check_bit("b_fifo_almful", 1'b0, o_b_fifo_almful);
      check_bit("s_bready", 1'b1, o_s_bready);
   endtask

   // master and slave models stepped once per rising edge
   task automatic drive_cycle();
      logic [63:0]     r;
      rr_pkg::axi_aw_t aw;
      rr_pkg::axi_aw_t burst;
      rr_pkg::axi_w_t  w;
      rr_pkg::axi_b_t  b;
      if (aw_fire) begin
         slv_aw_ids.push_back(i_m_aw.id);
      end
      if (w_fire && i_m_w.last) begin
         slv_wlast_cnt++;
      end
      if (!i_m_awvalid || aw_fire) begin
         r = rand_bits(1);
         if (gen_en && r[0]) begin
            r = rand_bits(rr_pkg::AXI_ID_W);
            aw.id = r[rr_pkg::AXI_ID_W-1:0];
            aw.addr = rand_bits(rr_pkg::AXI_ADDR_W);
            r = rand_bits(2);
            aw.len = '0;
            aw.len[1:0] = r[1:0];
            r = rand_bits(rr_pkg::AXI_SIZE_W);
            aw.size = r[rr_pkg::AXI_SIZE_W-1:0];
            w_todo.push_back(aw);
            aw_sent++;
            i_m_awvalid <= 1'b1;
            i_m_aw      <= aw;
         end else begin
            i_m_awvalid <= 1'b0;
         end
      end
      // W beats follow the bursts in issue order and may run ahead of their AW
      if (!i_m_wvalid || w_fire) begin
         if (w_beats_left == 0 && w_todo.size() > 0) begin
            burst = w_todo.pop_front();
            w_beats_left = int'(burst.len) + 1;
            w_id = burst.id;
         end
         r = rand_bits(2);
         if (w_beats_left > 0 && r[1:0] != 2'b00) begin
            w.id = w_id;
            w.data = rand_bits(rr_pkg::AXI_DATA_W);
            r = rand_bits(rr_pkg::AXI_STRB_W);
            w.strb = r[rr_pkg::AXI_STRB_W-1:0];
            w.last = (w_beats_left == 1);
            w_beats_left--;
            i_m_wvalid <= 1'b1;
            i_m_w      <= w;
         end else begin
            i_m_wvalid <= 1'b0;
         end
      end
      // slave answers a burst once its AW and its last W are both in
      if (!i_s_bvalid || sb_fire) begin
         r = rand_bits(3);
         if (slv_aw_ids.size() > 0 && slv_wlast_cnt > 0 && r[0]) begin
            b.id = slv_aw_ids.pop_front();
            b.resp = r[2:1];
            slv_wlast_cnt--;
            i_s_bvalid <= 1'b1;
            i_s_b      <= b;
         end else begin
            i_s_bvalid <= 1'b0;
         end
      end
      r = rand_bits(2);
      i_s_awready <= (r[1:0] != 2'b00);
      r = rand_bits(2);
      i_s_wready <= (r[1:0] != 2'b00);
      r = rand_bits(2);
      i_m_bready <= !hold_b && (r[1:0] != 2'b00);
      i_logb_almful <= sink_full;
   endtask

   task automatic run_phase(input string name, input int cycles, input bit gen,
                            input bit hold, input bit sink);
      test_name = name;
      gen_en = gen;
      hold_b = hold;
      sink_full = sink;
      repeat (cycles) begin
         @(posedge clk);
         drive_cycle();
      end
   endtask

   // outputs are settled at the falling edge where the compare process samples them
   always @(negedge clk) begin : compare
      bit             blk;
      rr_pkg::axi_b_t b_exp;
      if (check_en) begin
         blk = i_logb_almful || exp_almful;
         check_bit("aw_valid_out", i_m_awvalid && !blk, o_s_awvalid);
         check_bit("aw_ready_in", i_s_awready && !blk, o_m_awready);
         if (o_s_awvalid) begin
            check_aw("aw_pass", i_m_aw, o_s_aw);
         end
         check_bit("w_valid_out", i_m_wvalid && !blk, o_s_wvalid);
         check_bit("w_ready_in", i_s_wready && !blk, o_m_wready);
         if (o_s_wvalid) begin
            check_w("w_pass", i_m_w, o_s_w);
         end
         // records trail their handshake by one cycle
         check_bit("aw_record_strobe", aw_fire, o_logb_aw_valid);
         check_bit("aw_loge", aw_fire, o_loge_valid[rr_pkg::LOGE_AW]);
         if (aw_fire) begin
            check_aw("aw_record", exp_aw_q.pop_front(), o_logb_aw);
         end
         check_bit("w_record_strobe", w_fire, o_logb_w_valid);
         check_bit("w_loge", w_fire, o_loge_valid[rr_pkg::LOGE_W]);
         if (w_fire) begin
            check_w("w_record", exp_w_q.pop_front(), o_logb_w);
         end
         check_bit("b_record_strobe", mb_fire, o_logb_b_valid);
         check_bit("b_loge", mb_fire, o_loge_valid[rr_pkg::LOGE_B]);
         if (mb_fire) begin
            check_b("b_record", exp_b_q.pop_front(), o_logb_b);
         end
         check_bit("b_fifo_almful", exp_almful, o_b_fifo_almful);
         check_bit("s_bready", ref_buf.size() < B_BUF_DEPTH, o_s_bready);
         check_bit("m_bvalid", ref_buf.size() > 0 && !i_logb_almful, o_m_bvalid);
         if (o_m_bvalid && ref_buf.size() > 0) begin
            check_b("m_b", ref_buf[0], o_m_b);
         end
         if (exp_almful) begin
            almful_seen = 1'b1;
         end
         exp_almful = almful_ref(ref_buf.size());
         aw_fire = i_m_awvalid && i_s_awready && !blk;
         w_fire = i_m_wvalid && i_s_wready && !blk;
         sb_fire = i_s_bvalid && (ref_buf.size() < B_BUF_DEPTH);
         mb_fire = (ref_buf.size() > 0) && !i_logb_almful && i_m_bready;
         if (aw_fire) begin
            exp_aw_q.push_back(i_m_aw);
            aw_acc++;
         end
         if (w_fire) begin
            exp_w_q.push_back(i_m_w);
         end
         if (mb_fire) begin
            b_exp = ref_buf.pop_front();
            exp_b_q.push_back(b_exp);
            b_recv++;
         end
         if (sb_fire) begin
            ref_buf.push_back(i_s_b);
         end
      end
   end

   always @(posedge clk) begin : watchdog
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
         report_failure();
      end
   end

   initial begin : stimulus
      sync_rst_n    <= 1'b0;
      i_m_awvalid   <= 1'b0;
      i_m_aw        <= '0;
      i_m_wvalid    <= 1'b0;
      i_m_w         <= '0;
      i_m_bready    <= 1'b0;
      i_s_awready   <= 1'b0;
      i_s_wready    <= 1'b0;
      i_s_bvalid    <= 1'b0;
      i_s_b         <= '0;
      i_logb_almful <= 1'b0;
      repeat (RST_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      test_name = "reset";
      check_reset_state();
      @(posedge clk);
      sync_rst_n <= 1'b1;
      check_en = 1'b1;

      run_phase("random_traffic", RANDOM_CYCLES, 1'b1, 1'b0, 1'b0);
      run_phase("sink_almful", SINK_CYCLES, 1'b1, 1'b0, 1'b1);
      acc_before = aw_acc;
      run_phase("sink_release", RESUME_CYCLES, 1'b1, 1'b0, 1'b0);
      check_bit("traffic_resumed", 1'b1, aw_acc > acc_before);
      almful_seen = 1'b0;
      run_phase("bready_hold", HOLD_CYCLES, 1'b1, 1'b1, 1'b0);
      check_bit("almful_reached", 1'b1, almful_seen);

      // drain with no new bursts until everything outstanding has come back
      test_name = "drain";
      gen_en = 1'b0;
      hold_b = 1'b0;
      sink_full = 1'b0;
      drained = 1'b0;
      while (!drained) begin
         @(posedge clk);
         if (traffic_idle()) begin
            drained = 1'b1;
         end else begin
            drive_cycle();
         end
      end
      check_bit("all_responses_back", 1'b1, b_recv == aw_sent);

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- design/axi_write_recorder.sv
`timescale 1ns/10ps
`default_nettype none

// write-path recorder between an external master and an external slave
// AW and W pass through loggers, B goes through the response buffer
// before its logger, every accepted beat is copied to the logging port
module axi_write_recorder #(
   parameter int B_BUF_DEPTH = rr_pkg::B_BUF_DEPTH_DEF,
   parameter int B_BUF_SLACK = rr_pkg::B_BUF_SLACK_DEF
) (
   input  wire                        clk,
   input  wire                        sync_rst_n,

   // master side
   input  wire                        i_m_awvalid,
   input  wire rr_pkg::axi_aw_t       i_m_aw,
   output logic                       o_m_awready,
   input  wire                        i_m_wvalid,
   input  wire rr_pkg::axi_w_t        i_m_w,
   output logic                       o_m_wready,
   output logic                       o_m_bvalid,
   output rr_pkg::axi_b_t             o_m_b,
   input  wire                        i_m_bready,

   // slave side
   output logic                       o_s_awvalid,
   output rr_pkg::axi_aw_t            o_s_aw,
   input  wire                        i_s_awready,
   output logic                       o_s_wvalid,
   output rr_pkg::axi_w_t             o_s_w,
   input  wire                        i_s_wready,
   input  wire                        i_s_bvalid,
   input  wire rr_pkg::axi_b_t        i_s_b,
   output logic                       o_s_bready,

   // logging sink
   input  wire                        i_logb_almful,
   output logic                       o_logb_aw_valid,
   output rr_pkg::axi_aw_t            o_logb_aw,
   output logic                       o_logb_w_valid,
   output rr_pkg::axi_w_t             o_logb_w,
   output logic                       o_logb_b_valid,
   output rr_pkg::axi_b_t             o_logb_b,
   output logic [rr_pkg::LOGE_CNT-1:0] o_loge_valid,

   // status
   output logic                       o_b_fifo_almful
);

   logic           b_buf_almful;
   logic           wr_block;
   logic           b_buf_valid;
   rr_pkg::axi_b_t b_buf_data;
   logic           b_buf_ready;

   // new writes wait when the sink is nearly full or when the response
   // buffer could not take every outstanding response
   assign wr_block = i_logb_almful || b_buf_almful;

   axichannel_logger #(
      .T_PAYLOAD (rr_pkg::axi_aw_t)
   ) aw_logger (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .i_block      (wr_block),
      .i_in_valid   (i_m_awvalid),
      .i_in_data    (i_m_aw),
      .o_in_ready   (o_m_awready),
      .o_out_valid  (o_s_awvalid),
      .o_out_data   (o_s_aw),
      .i_out_ready  (i_s_awready),
      .o_logb_valid (o_logb_aw_valid),
      .o_logb_data  (o_logb_aw),
      .o_loge_valid (o_loge_valid[rr_pkg::LOGE_AW])
   );

   axichannel_logger #(
      .T_PAYLOAD (rr_pkg::axi_w_t)
   ) w_logger (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .i_block      (wr_block),
      .i_in_valid   (i_m_wvalid),
      .i_in_data    (i_m_w),
      .o_in_ready   (o_m_wready),
      .o_out_valid  (o_s_wvalid),
      .o_out_data   (o_s_w),
      .i_out_ready  (i_s_wready),
      .o_logb_valid (o_logb_w_valid),
      .o_logb_data  (o_logb_w),
      .o_loge_valid (o_loge_valid[rr_pkg::LOGE_W])
   );

   // slave responses land here first so they never back up into the slave
   b_resp_fifo #(
      .B_BUF_DEPTH (B_BUF_DEPTH),
      .B_BUF_SLACK (B_BUF_SLACK)
   ) b_buf (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .i_wr_valid (i_s_bvalid),
      .i_wr_data  (i_s_b),
      .o_wr_ready (o_s_bready),
      .o_rd_valid (b_buf_valid),
      .o_rd_data  (b_buf_data),
      .i_rd_ready (b_buf_ready),
      .o_almful   (b_buf_almful)
   );

   // B only waits on the sink, the buffer drains towards the master
   axichannel_logger #(
      .T_PAYLOAD (rr_pkg::axi_b_t)
   ) b_logger (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .i_block      (i_logb_almful),
      .i_in_valid   (b_buf_valid),
      .i_in_data    (b_buf_data),
      .o_in_ready   (b_buf_ready),
      .o_out_valid  (o_m_bvalid),
      .o_out_data   (o_m_b),
      .i_out_ready  (i_m_bready),
      .o_logb_valid (o_logb_b_valid),
      .o_logb_data  (o_logb_b),
      .o_loge_valid (o_loge_valid[rr_pkg::LOGE_B])
   );

   assign o_b_fifo_almful = b_buf_almful;

endmodule

`default_nettype wire

//--- design/axichannel_logger.sv
`timescale 1ns/10ps
`default_nettype none

// one valid/ready channel of the recorder
// the beat passes straight through, a copy of every accepted beat is
// registered and shows up on the logging side one cycle later
module axichannel_logger #(
   parameter type T_PAYLOAD = logic
) (
   input  wire      clk,
   input  wire      sync_rst_n,

   // stall request, from the logging sink or the response buffer
   input  wire      i_block,

   // upstream side
   input  wire      i_in_valid,
   input  wire      T_PAYLOAD i_in_data,
   output logic     o_in_ready,

   // downstream side
   output logic     o_out_valid,
   output T_PAYLOAD o_out_data,
   input  wire      i_out_ready,

   // logging side, one-cycle strobes
   output logic     o_logb_valid,
   output T_PAYLOAD o_logb_data,
   output logic     o_loge_valid
);

   logic     beat_acc;
   logic     log_strobe;
   T_PAYLOAD log_data;

   // a blocked channel looks idle to both ends
   assign o_out_valid = i_in_valid && !i_block;
   assign o_in_ready  = i_out_ready && !i_block;
   assign o_out_data  = i_in_data;

   // the beat moves when both sides see the handshake
   assign beat_acc = i_in_valid && i_out_ready && !i_block;

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         log_strobe <= 1'b0;
      end else begin
         log_strobe <= beat_acc;
      end
   end

   // capture the payload only on an accepted beat
   always_ff @(posedge clk) begin
      if (beat_acc) begin
         log_data <= i_in_data;
      end
   end

   assign o_logb_valid = log_strobe;
   assign o_logb_data  = log_data;
   // end marker rides along with the record
   assign o_loge_valid = log_strobe;

endmodule

`default_nettype wire

//--- design/b_resp_fifo.sv
`timescale 1ns/10ps
`default_nettype none

// response buffer on the B channel
// first word fall through: the head entry is visible while o_rd_valid is high
module b_resp_fifo #(
   parameter int B_BUF_DEPTH = rr_pkg::B_BUF_DEPTH_DEF,
   parameter int B_BUF_SLACK = rr_pkg::B_BUF_SLACK_DEF
) (
   input  wire                clk,
   input  wire                sync_rst_n,

   // write side, from the slave
   input  wire                i_wr_valid,
   input  wire rr_pkg::axi_b_t i_wr_data,
   output logic               o_wr_ready,

   // read side, towards the B logger
   output logic               o_rd_valid,
   output rr_pkg::axi_b_t     o_rd_data,
   input  wire                i_rd_ready,

   // registered near-full indication
   output logic               o_almful
);

   localparam int PTR_W = $clog2(B_BUF_DEPTH);
   localparam int CNT_W = PTR_W + 1;
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(B_BUF_DEPTH);
   // headroom kept for responses of bursts already issued
   localparam logic [CNT_W-1:0] ALMFUL_CNT = CNT_W'(B_BUF_DEPTH - B_BUF_SLACK);

   if (B_BUF_DEPTH < 4 || (1 << PTR_W) != B_BUF_DEPTH) begin : g_depth_chk
      $error("b_resp_fifo: depth %0d must be a power of two, 4 or more", B_BUF_DEPTH);
   end
   if (B_BUF_SLACK >= B_BUF_DEPTH) begin : g_slack_chk
      $error("b_resp_fifo: slack %0d must be below depth %0d", B_BUF_SLACK, B_BUF_DEPTH);
   end

   rr_pkg::axi_b_t   mem [B_BUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             wr_en;
   logic             rd_en;
   logic             almful_q;

   assign full  = (count == FULL_CNT);
   assign wr_en = i_wr_valid && !full;
   assign rd_en = o_rd_valid && i_rd_ready;

   // slave responses are taken whenever there is a free slot
   assign o_wr_ready = !full;
   assign o_rd_valid = (count != '0);
   assign o_rd_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_wr_data;
      end
   end

   // pointers wrap naturally since depth is a power of two
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // flag follows the occupancy one cycle late
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         almful_q <= 1'b0;
      end else begin
         almful_q <= (count >= ALMFUL_CNT);
      end
   end

   assign o_almful = almful_q;

endmodule

`default_nettype wire

//--- design/rr_pkg.sv
`default_nettype none

package rr_pkg;

   // axi field widths of the recorded write path
   localparam int AXI_ID_W   = 6;
   localparam int AXI_ADDR_W = 64;
   localparam int AXI_DATA_W = 64;
   localparam int AXI_STRB_W = AXI_DATA_W / 8;
   localparam int AXI_LEN_W  = 8;
   localparam int AXI_SIZE_W = 3;
   localparam int AXI_RESP_W = 2;

   // write address beat, 81 bits
   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_LEN_W-1:0]  len;
      logic [AXI_SIZE_W-1:0] size;
   } axi_aw_t;

   // write data beat, 79 bits
   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_DATA_W-1:0] data;
      logic [AXI_STRB_W-1:0] strb;
      logic                  last;
   } axi_w_t;

   // write response, 8 bits
   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_RESP_W-1:0] resp;
   } axi_b_t;

   // bit positions on the logging-end vector
   typedef enum int {
      LOGE_AW = 0,
      LOGE_W  = 1,
      LOGE_B  = 2
   } loge_ch_e;

   localparam int LOGE_CNT = 3;

   // response buffer sizing
   localparam int B_BUF_DEPTH_DEF = 64;
   // max outstanding write bursts plus some margin
   localparam int B_BUF_SLACK_DEF = 8;

endpackage

`default_nettype wire

//--- filelist.f
design/rr_pkg.sv
design/axichannel_logger.sv
design/b_resp_fifo.sv
design/axi_write_recorder.sv
bench/recorder_asserts.sv
bench/tb_axi_write_recorder.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f \
   --top-module tb_axi_write_recorder -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null \
   && echo "simulation ok" \
   || { echo "simulation failed"; exit 1; }
